// ==== design/pipe_macros.svh ====
`ifndef PIPE_MACROS_SVH
`define PIPE_MACROS_SVH

// **************************************************
// line and buffer geometry
// **************************************************

// bits per streamed line
`define PIPE_LINE_WIDTH 32

// fifo address bits, depth is 2**n entries
`define PIPE_FIFO_AWIDTH 4

// free entries still left when almostfull rises
`define PIPE_AFULL_MARGIN 4

`endif

// ==== design/pipe_types_pkg.sv ====
`include "pipe_macros.svh"

package pipe_types_pkg;

    // **************************************************
    // data widths
    // **************************************************

    // one streamed line
    typedef logic [`PIPE_LINE_WIDTH-1:0] line_t;

    // line count of one operation
    typedef logic [15:0] length_t;

    // extra msb tells full from empty
    typedef logic [`PIPE_FIFO_AWIDTH:0] fifo_ptr_t;

endpackage

// ==== design/pipe_ctrl_pkg.sv ====
package pipe_ctrl_pkg;

    import pipe_types_pkg::*;

    // rd_len first so it lines up with configreg[31:16]
    typedef struct packed {
        length_t rd_len;
        length_t wr_len;
    } op_config_t;

    typedef struct packed {
        logic  we;
        line_t wdata;
    } fifo_wr_t;

    typedef struct packed {
        logic  rvalid;
        line_t rdata;
    } fifo_rd_t;

    typedef struct packed {
        logic empty;
        logic full;
        logic almostfull;
    } fifo_status_t;

    // **************************************************
    // engine states
    // **************************************************
    typedef enum logic {WR_IDLE, WR_WRITE} write_state_t;
    typedef enum logic {RD_IDLE, RD_READ} read_state_t;

endpackage

// ==== design/write_fifo.sv ====
module write_fifo
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     op_start,
    input  pipe_types_pkg::length_t  wr_len,
    input  logic                     in_valid,
    input  pipe_types_pkg::line_t    in_data,
    output pipe_ctrl_pkg::fifo_wr_t  fifo_wr,
    output logic                     wr_done
);

    import pipe_types_pkg::*;
    import pipe_ctrl_pkg::*;

    write_state_t wr_state;

    length_t wr_len_q;
    length_t wr_cnt;   // lines accepted so far
    logic    we_q;
    line_t   wdata_q;
    logic    last_line;

    assign last_line = (wr_cnt == wr_len_q - 16'd1);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_state <= WR_IDLE;
            wr_cnt   <= '0;
            we_q     <= 1'b0;
            wr_done  <= 1'b0;
        end
        else
        begin
            we_q    <= 1'b0;
            wr_done <= 1'b0;
            case (wr_state)
                WR_IDLE:
                begin
                    if (op_start)
                    begin
                        wr_len_q <= wr_len;
                        wr_cnt   <= '0;
                        if (wr_len != '0)
                        begin
                            wr_state <= WR_WRITE;
                        end
                    end
                end

                WR_WRITE:
                begin
                    if (in_valid)
                    begin
                        we_q   <= 1'b1;
                        wr_cnt <= wr_cnt + 16'd1;
                        if (last_line)
                        begin
                            wr_done  <= 1'b1;   // lands with the final we
                            wr_state <= WR_IDLE;
                        end
                    end
                end

                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    // payload stage, follows the strobe
    always_ff @(posedge clk)
    begin
        if (in_valid)
        begin
            wdata_q <= in_data;
        end
    end

    assign fifo_wr = '{we: we_q, wdata: wdata_q};

endmodule

// ==== design/fifo_bram.sv ====
`include "pipe_macros.svh"

module fifo_bram
(
    input  logic                         clk,
    input  logic                         reset,
    input  pipe_ctrl_pkg::fifo_wr_t      fifo_wr,
    input  logic                         re,
    output pipe_ctrl_pkg::fifo_rd_t      fifo_rd,
    output pipe_ctrl_pkg::fifo_status_t  status
);

    import pipe_types_pkg::*;

    localparam int        DEPTH       = 1 << `PIPE_FIFO_AWIDTH;
    localparam fifo_ptr_t FULL_LEVEL  = fifo_ptr_t'(DEPTH);
    localparam fifo_ptr_t AFULL_LEVEL = fifo_ptr_t'(DEPTH - `PIPE_AFULL_MARGIN);

    line_t mem [DEPTH];

    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    fifo_ptr_t rd_ptr_next;
    fifo_ptr_t count;
    logic      wr_en;
    logic      rvalid_q;
    line_t     rdata_q;

    // **************************************************
    // write side
    // **************************************************
    assign wr_en = fifo_wr.we && !status.full;

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_ptr[`PIPE_FIFO_AWIDTH-1:0]] <= fifo_wr.wdata;
        end
    end

    // **************************************************
    // read side, one cycle latency
    // **************************************************
    always_ff @(posedge clk)
    begin
        if (re)
        begin
            rdata_q <= mem[rd_ptr[`PIPE_FIFO_AWIDTH-1:0]];
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            rvalid_q <= 1'b0;
        end
        else
        begin
            rvalid_q <= re;
            if (wr_en)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (re)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    assign fifo_rd = '{rvalid: rvalid_q, rdata: rdata_q};

    // status flags
    assign count       = wr_ptr - rd_ptr;
    assign rd_ptr_next = rd_ptr + fifo_ptr_t'(re);   // discount the read now in flight

    assign status.empty      = (count == '0) || (wr_ptr == rd_ptr_next);
    assign status.full       = (count == FULL_LEVEL);
    assign status.almostfull = (count >= AFULL_LEVEL);

endmodule

// ==== design/read_fifo.sv ====
module read_fifo
(
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         op_start,
    input  pipe_types_pkg::length_t      rd_len,
    input  pipe_ctrl_pkg::fifo_status_t  status,
    input  pipe_ctrl_pkg::fifo_rd_t      fifo_rd,
    input  logic                         out_almostfull,
    output logic                         re,
    output pipe_ctrl_pkg::fifo_rd_t      out_line,
    output logic                         rd_done
);

    import pipe_types_pkg::*;
    import pipe_ctrl_pkg::*;

    read_state_t rd_state;

    length_t rd_len_q;
    length_t issue_cnt;   // reads sent to the fifo
    length_t recv_cnt;    // lines come back
    logic    can_issue;
    logic    last_recv;

    assign can_issue = (issue_cnt < rd_len_q) && !status.empty && !out_almostfull;
    assign last_recv = fifo_rd.rvalid && (recv_cnt == rd_len_q - 16'd1);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_state  <= RD_IDLE;
            issue_cnt <= '0;
            recv_cnt  <= '0;
            re        <= 1'b0;
        end
        else
        begin
            re <= 1'b0;
            case (rd_state)
                RD_IDLE:
                begin
                    if (op_start)
                    begin
                        rd_len_q  <= rd_len;
                        issue_cnt <= '0;
                        recv_cnt  <= '0;
                        if (rd_len != '0)   // zero length stays idle
                        begin
                            rd_state <= RD_READ;
                        end
                    end
                end

                RD_READ:
                begin
                    if (can_issue)
                    begin
                        re        <= 1'b1;
                        issue_cnt <= issue_cnt + 16'd1;
                    end
                    if (fifo_rd.rvalid)
                    begin
                        recv_cnt <= recv_cnt + 16'd1;
                        if (last_recv)
                        begin
                            rd_state <= RD_IDLE;
                        end
                    end
                end

                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    // done rides on the last returning line
    assign rd_done  = (rd_state == RD_READ) && last_recv;
    assign out_line = fifo_rd;

endmodule

// ==== design/fifo_pipe_top.sv ====
module fifo_pipe_top
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     op_start,
    input  logic [31:0]              configreg,
    input  logic                     in_valid,
    input  pipe_types_pkg::line_t    in_data,
    input  logic                     out_almostfull,
    output logic                     in_almostfull,
    output pipe_ctrl_pkg::fifo_rd_t  out_line,
    output logic                     wr_done,
    output logic                     rd_done
);

    import pipe_ctrl_pkg::*;

    op_config_t   cfg;
    fifo_wr_t     fifo_wr;
    fifo_rd_t     fifo_rd;
    fifo_status_t fifo_status;
    logic         fifo_re;

    assign cfg.rd_len = configreg[31:16];
    assign cfg.wr_len = configreg[15:0];

    assign in_almostfull = fifo_status.almostfull;

    write_fifo u_write_fifo (
        .clk      (clk),
        .reset    (reset),
        .op_start (op_start),
        .wr_len   (cfg.wr_len),
        .in_valid (in_valid),
        .in_data  (in_data),
        .fifo_wr  (fifo_wr),
        .wr_done  (wr_done)
    );

    fifo_bram u_fifo_bram (
        .clk     (clk),
        .reset   (reset),
        .fifo_wr (fifo_wr),
        .re      (fifo_re),
        .fifo_rd (fifo_rd),
        .status  (fifo_status)
    );

    read_fifo u_read_fifo (
        .clk            (clk),
        .reset          (reset),
        .op_start       (op_start),
        .rd_len         (cfg.rd_len),
        .status         (fifo_status),
        .fifo_rd        (fifo_rd),
        .out_almostfull (out_almostfull),
        .re             (fifo_re),
        .out_line       (out_line),
        .rd_done        (rd_done)
    );

endmodule

// ==== tests/fifo_pipe_assertions.sv ====
module fifo_pipe_assertions
(
    input logic clk,
    input logic reset,
    input logic re,
    input logic empty,
    input logic full,
    input logic we,
    input logic rvalid,
    input logic done
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    // **************************************************
    // reset and read handshake
    // **************************************************

    quiet_after_reset: assert property (@(posedge clk) reset |=> !rvalid && !done)
    else
    begin
        $error("rvalid or a done pulse showed up right after reset");
        fail_count++;
    end

    // empty already discounts the read in flight, so look one cycle back
    no_read_when_empty: assert property (@(posedge clk) disable iff (reset) re |-> !$past(empty))
    else
    begin
        $error("re was issued although the fifo reported empty");
        fail_count++;
    end

    rvalid_after_re: assert property (@(posedge clk) disable iff (reset) re |=> rvalid)
    else
    begin
        $error("rvalid did not follow re by one cycle");
        fail_count++;
    end

    rvalid_needs_re: assert property (@(posedge clk) disable iff (reset) rvalid |-> $past(re))
    else
    begin
        $error("rvalid without a read one cycle before");
        fail_count++;
    end

    no_write_when_full: assert property (@(posedge clk) disable iff (reset) full |-> !we)
    else
    begin
        $error("a line was written while the fifo was full");
        fail_count++;
    end

endmodule

// ==== tests/fifo_pipe_checker.sv ====
module fifo_pipe_checker
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic [95:0]              test_name,
    input  logic                     op_start,
    input  logic [31:0]              configreg,
    input  logic                     in_valid,
    input  pipe_types_pkg::line_t    in_data,
    input  logic                     in_almostfull,
    input  logic                     out_almostfull,
    input  pipe_ctrl_pkg::fifo_rd_t  out_line,
    input  logic                     wr_done,
    input  logic                     rd_done
);

    timeunit 1ns;
    timeprecision 100ps;

    import pipe_types_pkg::*;

    line_t model_q[$];   // oldest unread line in front
    line_t expected;
    int    wr_left;
    int    rd_left;
    int    stalled_lines;   // lines taken since the sink stalled
    logic  wr_done_due;
    logic  rd_done_due;
    int    error_count  = 0;
    int    afull_cycles = 0;

    always @(negedge clk)
    begin
        if (reset)
        begin
            model_q.delete();
            wr_left       = 0;
            rd_left       = 0;
            stalled_lines = 0;
            wr_done_due   = 1'b0;
        end
        else
        begin
            if (in_almostfull)
            begin
                afull_cycles++;
            end

            // **************************************************
            // input side
            // **************************************************
            if (wr_done !== wr_done_due)
            begin
                $display("mismatch %0s: wr_done expected %b, actual %b",
                         test_name, wr_done_due, wr_done);
                error_count++;
            end
            wr_done_due = 1'b0;
            if (in_valid && wr_left > 0)
            begin
                model_q.push_back(in_data);
                wr_left--;
                wr_done_due = (wr_left == 0);   // one cycle after the last strobe
            end

            // **************************************************
            // output side
            // **************************************************
            rd_done_due = 1'b0;
            if (out_line.rvalid)
            begin
                if (model_q.size() == 0)
                begin
                    $display("error in %0s: a line came out that was never written", test_name);
                    error_count++;
                end
                else
                begin
                    expected = model_q.pop_front();
                    if (out_line.rdata !== expected)
                    begin
                        $display("mismatch %0s: expected %h, actual %h",
                                 test_name, expected, out_line.rdata);
                        error_count++;
                    end
                end
                if (rd_left == 0)
                begin
                    $display("error in %0s: a line came out with no read open", test_name);
                    error_count++;
                end
                else
                begin
                    rd_done_due = (rd_left == 1);
                    rd_left--;
                end
            end
            if (rd_done !== rd_done_due)
            begin
                $display("mismatch %0s: rd_done expected %b, actual %b",
                         test_name, rd_done_due, rd_done);
                error_count++;
            end

            // the sink still takes 2 lines issued before its stall
            if (out_almostfull)
            begin
                if (out_line.rvalid)
                begin
                    stalled_lines++;
                end
                if (stalled_lines > 2)
                begin
                    $display("error in %0s: more than 2 lines came out while the sink stalled",
                             test_name);
                    error_count++;
                    stalled_lines = 0;
                end
            end
            else
            begin
                stalled_lines = 0;
            end

            // strobes in this same cycle are still ignored by the engines
            if (op_start)
            begin
                if (wr_left != 0 || rd_left != 0)
                begin
                    $display("error in %0s: op_start while an operation was open", test_name);
                    error_count++;
                end
                wr_left = int'(configreg[15:0]);
                rd_left = int'(configreg[31:16]);
            end
        end
    end

    task automatic final_check();
        if (wr_left != 0 || rd_left != 0)
        begin
            $display("error: %0d writes and %0d reads never completed", wr_left, rd_left);
            error_count++;
        end
        if (model_q.size() != 0)
        begin
            $display("error: %0d written lines never came out", model_q.size());
            error_count++;
        end
    endtask

endmodule

// ==== tests/fifo_pipe_tb.sv ====
module fifo_pipe_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import pipe_types_pkg::*;
    import pipe_ctrl_pkg::*;

    localparam int NUM_TESTS       = 9;
    localparam int IDLE_GAP        = 8;
    localparam int WATCHDOG_MARGIN = 500;

    // names are exactly 12 characters
    typedef struct packed {
        logic [95:0] name;
        logic [15:0] wr_len;
        logic [15:0] rd_len;
        logic [7:0]  stall_pct;      // chance per cycle that the sink stalls
        logic        expect_afull;
    } test_row_t;

    logic        clk;
    logic        reset;
    logic        op_start;
    logic [31:0] configreg;
    logic        in_valid;
    line_t       in_data;
    logic        out_almostfull;
    logic        in_almostfull;
    fifo_rd_t    out_line;
    logic        wr_done;
    logic        rd_done;

    test_row_t   tests [NUM_TESTS];
    logic        table_ready = 1'b0;
    logic [95:0] cur_name    = "before_tests";
    int          stall_pct   = 0;
    int          seed        = 94709;
    int          stall_seed  = 94709;
    int          tb_errors   = 0;

    fifo_pipe_top UUT (
        .clk            (clk),
        .reset          (reset),
        .op_start       (op_start),
        .configreg      (configreg),
        .in_valid       (in_valid),
        .in_data        (in_data),
        .out_almostfull (out_almostfull),
        .in_almostfull  (in_almostfull),
        .out_line       (out_line),
        .wr_done        (wr_done),
        .rd_done        (rd_done)
    );

    fifo_pipe_checker u_checker (
        .clk            (clk),
        .reset          (reset),
        .test_name      (cur_name),
        .op_start       (op_start),
        .configreg      (configreg),
        .in_valid       (in_valid),
        .in_data        (in_data),
        .in_almostfull  (in_almostfull),
        .out_almostfull (out_almostfull),
        .out_line       (out_line),
        .wr_done        (wr_done),
        .rd_done        (rd_done)
    );

    bind fifo_bram fifo_pipe_assertions bram_checks (
        .clk    (clk),
        .reset  (reset),
        .re     (re),
        .empty  (status.empty),
        .full   (status.full),
        .we     (fifo_wr.we),
        .rvalid (fifo_rd.rvalid),
        .done   (1'b0)
    );

    bind read_fifo fifo_pipe_assertions read_checks (
        .clk    (clk),
        .reset  (reset),
        .re     (re),
        .empty  (status.empty),
        .full   (status.full),
        .we     (1'b0),
        .rvalid (fifo_rd.rvalid),
        .done   (rd_done)
    );

    // **************************************************
    // stimulus table
    // **************************************************
    task automatic fill_table();
        tests[0] = '{"simple_order", 16'd8,  16'd8,  8'd0,  1'b0};
        tests[1] = '{"leave_behind", 16'd10, 16'd6,  8'd20, 1'b0};   // 4 lines stay
        tests[2] = '{"drain_extras", 16'd4,  16'd8,  8'd0,  1'b0};
        tests[3] = '{"read_len_nil", 16'd6,  16'd0,  8'd0,  1'b0};
        tests[4] = '{"write_absent", 16'd0,  16'd6,  8'd10, 1'b0};
        tests[5] = '{"backpressure", 16'd40, 16'd40, 8'd90, 1'b1};
        tests[6] = '{"light_stalls", 16'd24, 16'd20, 8'd30, 1'b0};
        tests[7] = '{"both_len_nil", 16'd0,  16'd0,  8'd0,  1'b0};
        tests[8] = '{"long_streams", 16'd64, 16'd68, 8'd0,  1'b0};
    endtask

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // sink stall pattern
    initial
    begin
        out_almostfull = 1'b0;
        forever
        begin
            @(posedge clk);
            #2;
            if (stall_pct > 0)
            begin
                out_almostfull = (($unsigned($random(stall_seed)) % 100) < stall_pct);
            end
            else
            begin
                out_almostfull = 1'b0;
            end
        end
    end

    // source, holds off while in_almostfull is up
    task automatic stream_lines(input int count);
        int sent;
        sent = 0;
        while (sent < count)
        begin
            if (!in_almostfull)
            begin
                in_valid = 1'b1;
                in_data  = $random(seed);
                sent++;
            end
            else
            begin
                in_valid = 1'b0;
            end
            @(posedge clk);
            #2;
        end
        in_valid = 1'b0;
    endtask

    task automatic run_row(input test_row_t row);
        int afull_before;
        afull_before = u_checker.afull_cycles;
        @(posedge clk);
        cur_name  = row.name;
        stall_pct = int'(row.stall_pct);
        #2;
        configreg = {row.rd_len, row.wr_len};
        op_start  = 1'b1;
        @(posedge clk);
        #2;
        op_start = 1'b0;
        fork
            stream_lines(int'(row.wr_len));
            begin
                if (row.wr_len != '0)
                begin
                    @(negedge clk);
                    while (!wr_done)
                    begin
                        @(negedge clk);
                    end
                end
            end
            begin
                if (row.rd_len != '0)
                begin
                    @(negedge clk);
                    while (!rd_done)
                    begin
                        @(negedge clk);
                    end
                end
            end
        join
        @(posedge clk);
        stall_pct = 0;
        if (row.expect_afull && u_checker.afull_cycles == afull_before)
        begin
            $display("error in %0s: in_almostfull never rose under back-pressure", row.name);
            tb_errors++;
        end
        repeat (IDLE_GAP) @(posedge clk);
    endtask

    // watchdog sized from the table
    initial
    begin
        int limit;
        wait (table_ready);
        limit = WATCHDOG_MARGIN;
        for (int i = 0; i < NUM_TESTS; i++)
        begin
            limit += (int'(tests[i].wr_len) + int'(tests[i].rd_len)) * 8 + IDLE_GAP;
        end
        repeat (limit) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", limit);
        $display("TEST FAIL");
        $finish;
    end

    initial
    begin
        int assert_errors;
        int total;
        fill_table();
        table_ready = 1'b1;
        reset     = 1'b1;
        op_start  = 1'b0;
        configreg = '0;
        in_valid  = 1'b0;
        in_data   = '0;
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;

        for (int i = 0; i < NUM_TESTS; i++)
        begin
            run_row(tests[i]);
        end

        u_checker.final_check();
        assert_errors = UUT.u_fifo_bram.bram_checks.fail_count
                      + UUT.u_read_fifo.read_checks.fail_count;
        total = u_checker.error_count + tb_errors + assert_errors;
        $display("errors: checker %0d, testbench %0d, assertions %0d",
                 u_checker.error_count, tb_errors, assert_errors);
        if (total == 0)
        begin
            $display("TEST PASS");
        end
        else
        begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+design
design/pipe_types_pkg.sv
design/pipe_ctrl_pkg.sv
design/write_fifo.sv
design/fifo_bram.sv
design/read_fifo.sv
design/fifo_pipe_top.sv
tests/fifo_pipe_assertions.sv
tests/fifo_pipe_checker.sv
tests/fifo_pipe_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the fifo pipe testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module fifo_pipe_tb -f compile.f -Mdir obj_dir -o fifo_pipe_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

# keep running past assertion errors so the testbench gives its verdict
./obj_dir/fifo_pipe_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
    exit 1
fi

if ! grep -q "TEST PASS" "$LOG"; then
    echo "no verdict found in $LOG"
    exit 1
fi

exit 0
